// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_lsu
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== data_mem.sv ====
module data_mem #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                      clk,
    input  logic                      reset,
    input  lsu_pkg::mem_op_e          dec_op,
    input  logic [lsu_pkg::XLEN-1:0]  dec_addr,
    input  logic [lsu_pkg::XLEN-1:0]  dec_wdata,
    input  logic [4:0]                dec_rd,
    input  logic                      dec_fault,
    output lsu_pkg::mem_op_e          mem_op,
    output logic [lsu_pkg::XLEN-1:0]  mem_word,
    output logic [1:0]                mem_byte_sel,
    output logic [4:0]                mem_rd,
    output logic                      mem_fault
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int LANES = XLEN / 8;

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_sel;
    logic             wr_en;
    logic [LANES-1:0] wr_be;
    logic [XLEN-1:0]  wr_lanes;

    // word index wraps modulo the memory size
    assign word_idx = dec_addr[IDX_W+1:2];
    assign byte_sel = dec_addr[1:0];
    assign wr_en    = op_is_store(dec_op);

    // byte enables and replicated store data
    always_comb begin
        case (dec_op)
            OP_SB: begin
                wr_be    = 4'b0001 << byte_sel;
                wr_lanes = {LANES{dec_wdata[7:0]}};
            end
            OP_SH: begin
                wr_be    = byte_sel[1] ? 4'b1100 : 4'b0011;
                wr_lanes = {(LANES/2){dec_wdata[15:0]}};
            end
            OP_SW: begin
                wr_be    = 4'b1111;
                wr_lanes = dec_wdata;
            end
            default: begin
                wr_be    = 4'b0000;
                wr_lanes = dec_wdata;
            end
        endcase
    end

    // reset fill, then lane-merged writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'hFFFF_0000 + XLEN'(i);  // index pattern
            end
        end else if (wr_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (wr_be[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_lanes[8*b +: 8];  // untouched lanes kept
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_op    <= OP_NONE;
            mem_fault <= 1'b0;
        end else begin
            mem_op    <= dec_op;
            mem_fault <= dec_fault;
        end
    end

    // read sees the pre-write contents
    always_ff @(posedge clk) begin
        mem_word     <= mem[word_idx];
        mem_byte_sel <= byte_sel;
        mem_rd       <= dec_rd;
    end

endmodule

// ==== load_align.sv ====
module load_align (
    input  logic                      clk,
    input  logic                      reset,
    input  lsu_pkg::mem_op_e          mem_op,
    input  logic [lsu_pkg::XLEN-1:0]  mem_word,
    input  logic [1:0]                mem_byte_sel,
    input  logic [4:0]                mem_rd,
    input  logic                      mem_fault,
    output logic                      load_valid,
    output logic [lsu_pkg::XLEN-1:0]  load_data,
    output logic [4:0]                load_rd,
    output logic                      store_done,
    output logic                      access_fault
);
    import lsu_pkg::*;

    logic [7:0]      lane_byte;
    logic [15:0]     lane_half;
    logic [XLEN-1:0] aligned;

    assign lane_byte = mem_word[8*mem_byte_sel +: 8];
    assign lane_half = mem_byte_sel[1] ? mem_word[31:16] : mem_word[15:0];

    // extract and extend
    always_comb begin
        case (mem_op)
            OP_LB:   aligned = {{(XLEN-8){lane_byte[7]}}, lane_byte};
            OP_LBU:  aligned = {{(XLEN-8){1'b0}}, lane_byte};
            OP_LH:   aligned = {{(XLEN-16){lane_half[15]}}, lane_half};
            OP_LHU:  aligned = {{(XLEN-16){1'b0}}, lane_half};
            default: aligned = mem_word;  // LW and everything else
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid   <= 1'b0;
            store_done   <= 1'b0;
            access_fault <= 1'b0;
        end else begin
            load_valid   <= op_is_load(mem_op);
            store_done   <= op_is_store(mem_op);
            access_fault <= mem_fault;
        end
    end

    always_ff @(posedge clk) begin
        if (op_is_load(mem_op)) begin
            load_data <= aligned;
            load_rd   <= mem_rd;
        end
    end

endmodule

// ==== lsu_chk.sv ====
module lsu_chk (
    input logic clk,
    input logic reset,
    input logic load_valid,
    input logic store_done,
    input logic access_fault
);
    timeunit 1ns;
    timeprecision 100ps;

    // one result per cycle at most
    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({load_valid, store_done, access_fault})
    ) else $error("more than one result strobe high in the same cycle");

    // pipe is empty during reset and just after
    a_quiet_reset: assert property (
        @(posedge clk) ($past(reset) || $past(reset, 2))
        |-> !(load_valid || store_done || access_fault)
    ) else $error("result strobe high during or right after reset");

    a_fault_no_load: assert property (
        @(posedge clk) disable iff (reset)
        access_fault |-> !load_valid
    ) else $error("access_fault and load_valid high together");

endmodule

bind lsu_top lsu_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .load_valid   (load_valid),
    .store_done   (store_done),
    .access_fault (access_fault)
);

// ==== lsu_pkg.sv ====
package lsu_pkg;

    localparam int XLEN = 32;  // data and address width

    // RV32I major opcodes handled here
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // funct3 size codes, shared by loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;  // loads only
    localparam logic [2:0] F3_HU = 3'b101;  // loads only

    // memory operation carried down the pipe
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    function automatic logic op_is_load(input mem_op_e op);
        return (op == OP_LB) || (op == OP_LH) || (op == OP_LW) ||
               (op == OP_LBU) || (op == OP_LHU);
    endfunction

    function automatic logic op_is_store(input mem_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

endpackage

// ==== lsu_top.sv ====
module lsu_top #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  logic [31:0]               inst,
    input  logic [lsu_pkg::XLEN-1:0]  rs1_val,
    input  logic [lsu_pkg::XLEN-1:0]  rs2_val,
    output logic                      load_valid,
    output logic [lsu_pkg::XLEN-1:0]  load_data,
    output logic [4:0]                load_rd,
    output logic                      store_done,
    output logic                      access_fault
);
    import lsu_pkg::*;

    // stage 1 to stage 2
    mem_op_e         dec_op;
    logic [XLEN-1:0] dec_addr;
    logic [XLEN-1:0] dec_wdata;
    logic [4:0]      dec_rd;
    logic            dec_fault;

    // stage 2 to stage 3
    mem_op_e         mem_op;
    logic [XLEN-1:0] mem_word;
    logic [1:0]      mem_byte_sel;
    logic [4:0]      mem_rd;
    logic            mem_fault;

    mem_op_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .dec_op     (dec_op),
        .dec_addr   (dec_addr),
        .dec_wdata  (dec_wdata),
        .dec_rd     (dec_rd),
        .dec_fault  (dec_fault)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk          (clk),
        .reset        (reset),
        .dec_op       (dec_op),
        .dec_addr     (dec_addr),
        .dec_wdata    (dec_wdata),
        .dec_rd       (dec_rd),
        .dec_fault    (dec_fault),
        .mem_op       (mem_op),
        .mem_word     (mem_word),
        .mem_byte_sel (mem_byte_sel),
        .mem_rd       (mem_rd),
        .mem_fault    (mem_fault)
    );

    load_align u_align (
        .clk          (clk),
        .reset        (reset),
        .mem_op       (mem_op),
        .mem_word     (mem_word),
        .mem_byte_sel (mem_byte_sel),
        .mem_rd       (mem_rd),
        .mem_fault    (mem_fault),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .load_rd      (load_rd),
        .store_done   (store_done),
        .access_fault (access_fault)
    );

endmodule

// ==== mem_op_decode.sv ====
module mem_op_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  logic [31:0]               inst,
    input  logic [lsu_pkg::XLEN-1:0]  rs1_val,
    input  logic [lsu_pkg::XLEN-1:0]  rs2_val,
    output lsu_pkg::mem_op_e          dec_op,
    output logic [lsu_pkg::XLEN-1:0]  dec_addr,
    output logic [lsu_pkg::XLEN-1:0]  dec_wdata,
    output logic [4:0]                dec_rd,
    output logic                      dec_fault
);
    import lsu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_load;
    logic            is_store;
    logic [11:0]     imm;
    logic [XLEN-1:0] eff_addr;
    mem_op_e         op;
    logic            bad_f3;
    logic            misaligned;
    logic            fault;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign is_load  = (opcode == OPCODE_LOAD);
    assign is_store = (opcode == OPCODE_STORE);

    // S-type splits the immediate around rd
    assign imm      = is_store ? {inst[31:25], inst[11:7]} : inst[31:20];
    assign eff_addr = rs1_val + {{(XLEN-12){imm[11]}}, imm};

    // funct3 to operation
    always_comb begin
        op     = OP_NONE;
        bad_f3 = 1'b0;
        if (is_load) begin
            case (funct3)
                F3_B:    op = OP_LB;
                F3_H:    op = OP_LH;
                F3_W:    op = OP_LW;
                F3_BU:   op = OP_LBU;
                F3_HU:   op = OP_LHU;
                default: bad_f3 = 1'b1;
            endcase
        end else if (is_store) begin
            case (funct3)
                F3_B:    op = OP_SB;
                F3_H:    op = OP_SH;
                F3_W:    op = OP_SW;
                default: bad_f3 = 1'b1;  // no unsigned stores
            endcase
        end
    end

    // natural alignment per access size
    always_comb begin
        case (op)
            OP_LH, OP_LHU, OP_SH: misaligned = eff_addr[0];
            OP_LW, OP_SW:         misaligned = |eff_addr[1:0];
            default:              misaligned = 1'b0;  // bytes never fault
        endcase
    end

    assign fault = bad_f3 | misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_op    <= OP_NONE;
            dec_fault <= 1'b0;
        end else begin
            dec_op    <= (inst_valid && !fault) ? op : OP_NONE;  // faults squashed here
            dec_fault <= inst_valid && fault;
        end
    end

    // payload, only meaningful alongside dec_op
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec_addr  <= eff_addr;
            dec_wdata <= rs2_val;
            dec_rd    <= is_load ? inst[11:7] : 5'd0;  // stores have no rd
        end
    end

endmodule

// ==== sim.f ====
lsu_pkg.sv
mem_op_decode.sv
data_mem.sv
load_align.sv
lsu_top.sv
lsu_chk.sv
tb_lsu.sv

// ==== tb_lsu.sv ====
module tb_lsu;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    localparam int MEM_WORDS      = 4096;
    localparam int IDX_W          = $clog2(MEM_WORDS);
    localparam int CLK_PERIOD     = 100;
    localparam int OP_BUDGET      = 110;  // upper bound on issued instructions
    localparam int TIMEOUT_CYCLES = OP_BUDGET * 10 + 100;

    // one expected result and the cycle it is due
    typedef struct packed {
        logic [31:0]     due;
        mem_op_e         op;
        logic            fault;
        logic [XLEN-1:0] data;
        logic [4:0]      rd;
    } expect_t;

    logic            clk;
    logic            reset;
    logic            reset_q;  // reset as seen by the last rising edge
    logic            inst_valid;
    logic [31:0]     inst;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            load_valid;
    logic [XLEN-1:0] load_data;
    logic [4:0]      load_rd;
    logic            store_done;
    logic            access_fault;

    logic [XLEN-1:0] shadow [MEM_WORDS];  // reference copy of the memory
    expect_t         exp_q [$];
    expect_t         head;
    logic [31:0]     lcg_state = 32'd60;
    logic [31:0]     cyc = 32'd0;
    int              checks;
    int              mismatches;
    int              strobe_errors;

    lsu_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .load_rd      (load_rd),
        .store_done   (store_done),
        .access_fault (access_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    always @(posedge clk) reset_q <= reset;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [11:0] imm);
        return {imm, 5'd1, f3, rd, OPCODE_LOAD};  // base in x1
    endfunction

    function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic mem_op_e load_op_of(input logic [2:0] f3);
        case (f3)
            F3_B:    return OP_LB;
            F3_H:    return OP_LH;
            F3_W:    return OP_LW;
            F3_BU:   return OP_LBU;
            F3_HU:   return OP_LHU;
            default: return OP_NONE;
        endcase
    endfunction

    function automatic mem_op_e store_op_of(input logic [2:0] f3);
        case (f3)
            F3_B:    return OP_SB;
            F3_H:    return OP_SH;
            F3_W:    return OP_SW;
            default: return OP_NONE;
        endcase
    endfunction

    function automatic logic is_unaligned(input mem_op_e op, input logic [XLEN-1:0] addr);
        case (op)
            OP_LH, OP_LHU, OP_SH: return addr[0];
            OP_LW, OP_SW:         return addr[1:0] != 2'b00;
            default:              return 1'b0;
        endcase
    endfunction

    // predicted load result from the shadow word
    function automatic logic [XLEN-1:0] load_value(input mem_op_e op, input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        logic [7:0]      b;
        logic [15:0]     h;
        word = shadow[addr[IDX_W+1:2]];
        b    = word[8*addr[1:0] +: 8];
        h    = word[16*addr[1] +: 16];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic expect_t make_expect(input mem_op_e op, input logic fault,
                                            input logic [XLEN-1:0] data, input logic [4:0] rd);
        expect_t e;
        e.due   = 32'd0;
        e.op    = op;
        e.fault = fault;
        e.data  = data;
        e.rd    = rd;
        return e;
    endfunction

    task automatic shadow_store(input mem_op_e op, input logic [XLEN-1:0] addr,
                                input logic [XLEN-1:0] data);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W+1:2];
        case (op)
            OP_SB:   shadow[idx][8*addr[1:0] +: 8] = data[7:0];
            OP_SH:   shadow[idx][16*addr[1] +: 16] = data[15:0];
            OP_SW:   shadow[idx] = data;
            default: ;
        endcase
    endtask

    task automatic drive(input logic [31:0] word, input logic [XLEN-1:0] rs1,
                         input logic [XLEN-1:0] rs2, input expect_t e);
        expect_t entry;
        entry = e;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        rs1_val    = rs1;
        rs2_val    = rs2;
        entry.due  = cyc + 32'd3;  // three registers deep
        exp_q.push_back(entry);
    endtask

    task automatic issue_load(input logic [2:0] f3, input logic [4:0] rd,
                              input logic [XLEN-1:0] base, input logic [11:0] imm);
        logic [XLEN-1:0] addr;
        mem_op_e         op;
        logic            fault;
        addr  = base + {{20{imm[11]}}, imm};
        op    = load_op_of(f3);
        fault = (op == OP_NONE) || is_unaligned(op, addr);
        if (fault) begin
            drive(load_inst(f3, rd, imm), base, lcg_next(), make_expect(OP_NONE, 1'b1, '0, '0));
        end else begin
            drive(load_inst(f3, rd, imm), base, lcg_next(),
                  make_expect(op, 1'b0, load_value(op, addr), rd));
        end
    endtask

    task automatic issue_store(input logic [2:0] f3, input logic [XLEN-1:0] base,
                               input logic [11:0] imm, input logic [XLEN-1:0] data);
        logic [XLEN-1:0] addr;
        mem_op_e         op;
        logic            fault;
        addr  = base + {{20{imm[11]}}, imm};
        op    = store_op_of(f3);
        fault = (op == OP_NONE) || is_unaligned(op, addr);
        if (!fault) begin
            shadow_store(op, addr, data);
        end
        drive(store_inst(f3, imm), base, data, make_expect(fault ? OP_NONE : op, fault, '0, '0));
    endtask

    task automatic drain();
        @(negedge clk);
        inst_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic strobe_match(input string name, input logic expected, input logic seen,
                                input mem_op_e op);
        if (expected && seen !== 1'b1) begin
            strobe_errors++;
            $display("ERROR at %0t: %s did not pulse for expected op %s", $time, name, op.name());
        end else if (!expected && seen !== 1'b0) begin
            strobe_errors++;
            $display("ERROR at %0t: %s pulsed although no such result was due", $time, name);
        end
    endtask

    task automatic check_event(input mem_op_e exp_op, input logic exp_fault);
        logic exp_load;
        logic exp_store;
        exp_load  = exp_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
        exp_store = exp_op inside {OP_SB, OP_SH, OP_SW};
        checks++;
        strobe_match("load_valid", exp_load, load_valid, exp_op);
        strobe_match("store_done", exp_store, store_done, exp_op);
        strobe_match("access_fault", exp_fault, access_fault, exp_op);
    endtask

    task automatic check_load(input logic [XLEN-1:0] exp_data, input logic [4:0] exp_rd);
        checks++;
        if (load_data !== exp_data) begin
            mismatches++;
            $display("MISMATCH at %0t: load_data %h, expected %h", $time, load_data, exp_data);
        end
        if (load_rd !== exp_rd) begin
            mismatches++;
            $display("MISMATCH at %0t: load_rd %0d, expected %0d", $time, load_rd, exp_rd);
        end
    endtask

    // scoreboard samples at the falling edge where outputs are stable
    initial begin
        forever begin
            @(negedge clk);
            if (!reset_q) begin
                if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                    head = exp_q.pop_front();
                    check_event(head.op, head.fault);
                    if (head.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
                        check_load(head.data, head.rd);
                    end
                end else begin
                    check_event(OP_NONE, 1'b0);  // idle cycle
                end
            end
        end
    end

    task automatic test_reset_pattern();
        issue_load(F3_W, 5'd1, 32'h0000_0000, 12'h000);
        issue_load(F3_W, 5'd2, 32'h0000_0000, 12'h01C);
        issue_load(F3_W, 5'd3, 32'h0000_0190, 12'h000);
        issue_load(F3_W, 5'd4, 32'h0000_4000, 12'hFFC);  // last word via a negative offset
        issue_load(F3_W, 5'd5, 32'h0001_0008, 12'h000);  // wraps to word 2
        issue_load(F3_W, 5'd6, 32'h0000_2004, 12'h7FC);
        drain();
    endtask

    task automatic test_word_stores();
        logic [31:0] r;
        logic [31:0] base;
        for (int i = 0; i < 4; i++) begin
            r    = lcg_next();
            base = {18'd0, r[13:2], 2'b00};
            issue_store(F3_W, base, 12'h000, lcg_next());
            issue_load(F3_W, 5'(i + 8), base, 12'h000);  // very next cycle
        end
        drain();
    endtask

    task automatic test_lane_stores();
        for (int lane = 0; lane < 4; lane++) begin
            issue_store(F3_B, 32'h0000_0800, 12'(lane), lcg_next());
            issue_load(F3_W, 5'd10, 32'h0000_0800, 12'h000);
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            issue_store(F3_H, 32'h0000_0804, 12'(lane), lcg_next());
            issue_load(F3_W, 5'd11, 32'h0000_0804, 12'h000);
        end
        drain();
    endtask

    task automatic test_narrow_loads();
        logic [31:0] words [2];
        logic [31:0] base;
        words[0] = 32'h9A80_01FF;  // lane tops set, clear, set, set
        words[1] = lcg_next();
        for (int w = 0; w < 2; w++) begin
            base = 32'h0000_0C00 + 32'(w * 4);
            issue_store(F3_W, base, 12'h000, words[w]);
            for (int lane = 0; lane < 4; lane++) begin
                issue_load(F3_B, 5'(lane + 16), base, 12'(lane));
                issue_load(F3_BU, 5'(lane + 20), base, 12'(lane));
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                issue_load(F3_H, 5'(lane + 24), base, 12'(lane));
                issue_load(F3_HU, 5'(lane + 25), base, 12'(lane));
            end
        end
        drain();
    endtask

    task automatic test_faults();
        issue_load(F3_H, 5'd3, 32'h0000_0200, 12'h001);
        issue_load(F3_HU, 5'd3, 32'h0000_0200, 12'h003);
        issue_load(F3_W, 5'd4, 32'h0000_0200, 12'h002);
        issue_store(F3_H, 32'h0000_0200, 12'h001, 32'h1234_5678);
        issue_store(F3_W, 32'h0000_0200, 12'h003, 32'hDEAD_BEEF);
        issue_load(3'b011, 5'd5, 32'h0000_0200, 12'h000);  // LD is RV64 only
        issue_store(3'b011, 32'h0000_0200, 12'h000, 32'hCAFE_F00D);
        issue_load(F3_W, 5'd6, 32'h0000_0200, 12'h000);    // word must be untouched
        drive({12'h010, 5'd1, 3'b000, 5'd7, 7'b0010011}, 32'h0, 32'h0,
              make_expect(OP_NONE, 1'b0, '0, '0));         // addi is ignored
        drain();
    endtask

    task automatic test_stream();
        logic [31:0] r;
        logic [11:0] imm;
        for (int n = 0; n < 40; n++) begin
            r   = lcg_next();
            imm = {6'd0, r[13:8]};  // 16-word window
            case (r[30:28])
                3'd0:    issue_load(F3_B, r[20:16], 32'h0000_1000, imm);
                3'd1:    issue_load(F3_BU, r[20:16], 32'h0000_1000, imm);
                3'd2:    issue_load(F3_H, r[20:16], 32'h0000_1000, imm & 12'hFFE);
                3'd3:    issue_load(F3_HU, r[20:16], 32'h0000_1000, imm & 12'hFFE);
                3'd4:    issue_load(F3_W, r[20:16], 32'h0000_1000, imm & 12'hFFC);
                3'd5:    issue_store(F3_B, 32'h0000_1000, imm, lcg_next());
                3'd6:    issue_store(F3_H, 32'h0000_1000, imm & 12'hFFE, lcg_next());
                default: issue_store(F3_W, 32'h0000_1000, imm & 12'hFFC, lcg_next());
            endcase
        end
        drain();
    endtask

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_val    = '0;
        rs2_val    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'hFFFF_0000 + 32'(i);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_pattern();
        test_word_stores();
        test_lane_stores();
        test_narrow_loads();
        test_faults();
        test_stream();
        repeat (4) @(negedge clk);  // quiet tail
        $display("checks %0d, value mismatches %0d, strobe errors %0d",
                 checks, mismatches, strobe_errors);
        if (mismatches == 0 && strobe_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule
